/* Makefile */
TOP := tb_xadc_frame

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
    output logic clk125,
    output logic rst
);
    initial
    begin
        clk125 = 1'b0;
        forever #5 clk125 = ~clk125;  // 10 ns period
    end

    // reset over the first four rising edges
    initial
    begin
        rst = 1'b1;
        repeat (4) @(posedge clk125);
        #1;
        rst = 1'b0;
    end
endmodule

`default_nettype wire

/* bench/tb_xadc_frame.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_frame_params.svh"

module tb_xadc_frame;
    import adc_types_pkg::*;
    import frame_pkg::*;

    localparam int num_runs = 4;

    // run table, one entry per run
    localparam vmm_id_t       run_vmm   [num_runs] = '{16'h0005, 16'h0008, 16'h0003, 16'h01fc};
    localparam sample_count_t run_size  [num_runs] = '{11'd7, 11'd6, 11'd760, 11'd4};
    localparam delay_t        run_delay [num_runs] = '{18'd2, 18'd1, 18'd0, 18'd5};

    logic          clk125;
    logic          rst;
    logic          data_in_rdy;
    vmm_id_t       vmm_id;
    sample_count_t sample_size;
    delay_t        delay_in;
    logic          udp_done;
    logic          conv_done;
    sample_t       conv_result;
    logic          conv_start;
    channel_t      conv_channel;
    logic          busy;
    word_t         fifo_bus;
    logic          data_fifo_enable;
    frame_len_t    packet_len;
    logic          end_of_data;

    int          errors = 0;
    int          cyc = 0;
    int          conv_idx = 0;    // conversions in the current run
    int          last_done = 0;   // cycle of the previous conv_done
    logic [31:0] rnd_state = 32'hc61b_4b33;
    sample_t     res_q [8][$];    // converter results per channel
    word_t       got_word [$];
    frame_len_t  got_len [$];
    logic        got_eod [$];
    logic        run_all;
    channel_t    run_ch;
    int          cur_size;
    int          cur_delay;

    clock_gen clk0 (.clk125(clk125), .rst(rst));

    xadc_frame_top dut0
    (
        .clk125           (clk125),
        .rst              (rst),
        .data_in_rdy      (data_in_rdy),
        .vmm_id           (vmm_id),
        .sample_size      (sample_size),
        .delay_in         (delay_in),
        .udp_done         (udp_done),
        .conv_done        (conv_done),
        .conv_result      (conv_result),
        .conv_start       (conv_start),
        .conv_channel     (conv_channel),
        .busy             (busy),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data)
    );

    always @(posedge clk125)
        cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    function automatic channel_t expected_channel(input int idx);
        if (run_all)
            return channel_t'(idx / cur_size);
        return run_ch;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = 2000;  // reset, handshakes, slack
        for (int r = 0; r < num_runs; r++)
            total += ((run_vmm[r][3:0] > 4'd7) ? 8 : 1) * int'(run_size[r])
                     * (int'(run_delay[r]) + 20);
        return total;
    endfunction

    ////////////////////////////////////////
    // converter model and FIFO monitor
    ////////////////////////////////////////

    initial
    begin : converter
        channel_t ch;
        int       lat;
        conv_done   = 1'b0;
        conv_result = '0;
        forever
        begin
            @(negedge clk125);
            if (!rst && conv_start)
            begin
                ch = conv_channel;
                if (ch !== expected_channel(conv_idx))
                    report_mismatch("conv_channel", 64'(ch), 64'(expected_channel(conv_idx)));
                // spacing only applies inside a channel
                if ((conv_idx % cur_size) != 0 && (cyc - last_done) < cur_delay + 1)
                begin
                    errors++;
                    $display("error t=%0t: conv_start %0d cycles after conv_done, delay_in %0d",
                             $time, cyc - last_done, cur_delay);
                end
                conv_idx++;
                rnd_state = xorshift32(rnd_state);
                lat = 3 + int'(rnd_state[2:0]);  // 3 to 10 cycles
                rnd_state = xorshift32(rnd_state);
                repeat (lat) @(posedge clk125);
                #1;
                conv_done   = 1'b1;
                conv_result = rnd_state[11:0];
                res_q[ch].push_back(rnd_state[11:0]);
                last_done = cyc;
                @(posedge clk125);
                #1;
                conv_done = 1'b0;
            end
        end
    end

    always @(negedge clk125)
    begin
        if (!rst && data_fifo_enable)
        begin
            got_word.push_back(fifo_bus);
            got_len.push_back(packet_len);
            got_eod.push_back(end_of_data);
        end
        if (!rst && end_of_data && !data_fifo_enable)
        begin
            errors++;
            $display("error t=%0t: end_of_data without a FIFO strobe", $time);
        end
    end

    ////////////////////////////////////////
    // one table row
    ////////////////////////////////////////

    task automatic do_run(input int r);
        int       n_ch;
        int       n_words;
        int       w;
        int       wait_cnt;
        int       err0;
        int       len;
        int       idx;
        int       ch_words;
        channel_t ch;
        word_t    exp_word;
        logic     eod;
        err0      = errors;
        run_all   = (run_vmm[r][3:0] > 4'd7);
        run_ch    = run_vmm[r][2:0];
        cur_size  = int'(run_size[r]);
        cur_delay = int'(run_delay[r]);
        n_ch      = run_all ? `ADC_NUM_CHANNELS : 1;
        ch_words  = (cur_size + `ADC_SLOTS_PER_WORD - 1) / `ADC_SLOTS_PER_WORD;
        n_words   = n_ch * ch_words;
        conv_idx  = 0;
        for (int c = 0; c < 8; c++)
            res_q[c].delete();
        got_word.delete();
        got_len.delete();
        got_eod.delete();

        @(posedge clk125);
        #1;
        vmm_id      = run_vmm[r];
        sample_size = run_size[r];
        delay_in    = run_delay[r];
        data_in_rdy = 1'b1;
        udp_done    = 1'b0;
        @(negedge clk125);  // start is taken at the next edge
        if (busy !== 1'b0)
            report_mismatch("busy", 64'(busy), 64'd0);
        @(negedge clk125);
        if (busy !== 1'b1)
            report_mismatch("busy", 64'(busy), 64'd1);

        while (got_word.size() < n_words)
            @(negedge clk125);

        // FIFO quiet, udp_done still low
        repeat (4)
        begin
            @(negedge clk125);
            if (busy !== 1'b1)
                report_mismatch("busy", 64'(busy), 64'd1);
        end
        @(posedge clk125);
        #1;
        udp_done = 1'b1;
        repeat (2)
        begin
            @(negedge clk125);
            if (busy !== 1'b1)  // data_in_rdy still high
                report_mismatch("busy", 64'(busy), 64'd1);
        end
        @(posedge clk125);
        #1;
        data_in_rdy = 1'b0;
        udp_done    = 1'b0;
        repeat (2)
        begin
            @(negedge clk125);
            if (busy !== 1'b1)  // udp_done low again
                report_mismatch("busy", 64'(busy), 64'd1);
        end
        @(posedge clk125);
        #1;
        udp_done = 1'b1;
        wait_cnt = 0;
        while (busy && wait_cnt < 10)
        begin
            @(negedge clk125);
            wait_cnt++;
        end
        if (busy !== 1'b0)
        begin
            errors++;
            $display("error t=%0t: busy still high after release", $time);
        end

        if (got_word.size() != n_words)
        begin
            errors++;
            $display("error: run %0d gave %0d words, expected %0d", r, got_word.size(), n_words);
        end
        w = 0;
        for (int c = 0; c < n_ch; c++)
        begin
            ch = run_all ? channel_t'(c) : run_ch;
            if (res_q[ch].size() != cur_size)
            begin
                errors++;
                $display("error: run %0d channel %0d took %0d results, expected %0d",
                         r, ch, res_q[ch].size(), cur_size);
            end
            for (int i = 0; i < ch_words; i++)
            begin
                exp_word = '0;
                exp_word[63:60] = {1'b0, ch};
                for (int k = 0; k < `ADC_SLOTS_PER_WORD; k++)
                begin
                    idx = `ADC_SLOTS_PER_WORD * i + k;
                    if (idx < cur_size && idx < res_q[ch].size())
                        exp_word[12*k +: 12] = res_q[ch][idx];
                end
                len = (i % `ADC_MAX_FRAME_WORDS) + 1;
                eod = (len == `ADC_MAX_FRAME_WORDS) || (i == ch_words - 1);
                if (w < got_word.size())
                begin
                    if (got_word[w] !== exp_word)
                        report_mismatch("fifo_bus", got_word[w], exp_word);
                    if (got_len[w] !== frame_len_t'(len))
                        report_mismatch("packet_len", 64'(got_len[w]), 64'(len));
                    if (got_eod[w] !== eod)
                        report_mismatch("end_of_data", 64'(got_eod[w]), 64'(eod));
                end
                w++;
            end
        end
        $display("run %0d: vmm_id %h, %0d samples, delay %0d, %0d words, %s", r, run_vmm[r],
                 cur_size, cur_delay, got_word.size(), (errors == err0) ? "ok" : "mismatch");
    endtask

    initial
    begin : main
        int bad_runs;
        int err0;
        bad_runs    = 0;
        data_in_rdy = 1'b0;
        vmm_id      = '0;
        sample_size = '0;
        delay_in    = '0;
        udp_done    = 1'b1;
        @(negedge clk125);
        while (rst)
            @(negedge clk125);
        // quiet outputs out of reset
        if (busy !== 1'b0)
            report_mismatch("busy", 64'(busy), 64'd0);
        if (conv_start !== 1'b0)
            report_mismatch("conv_start", 64'(conv_start), 64'd0);
        if (data_fifo_enable !== 1'b0)
            report_mismatch("data_fifo_enable", 64'(data_fifo_enable), 64'd0);
        if (end_of_data !== 1'b0)
            report_mismatch("end_of_data", 64'(end_of_data), 64'd0);
        for (int r = 0; r < num_runs; r++)
        begin
            err0 = errors;
            do_run(r);
            if (errors != err0)
                bad_runs++;
        end
        $display("runs %0d, runs with errors %0d, errors %0d", num_runs, bad_runs, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk125);
        $display("error: runs did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* include/adc_frame_params.svh */
`ifndef ADC_FRAME_PARAMS_SVH
`define ADC_FRAME_PARAMS_SVH

////////////////////////////////////////
// frame sizing
////////////////////////////////////////

// words in one frame before end_of_data is forced
`define ADC_MAX_FRAME_WORDS 150

// 12-bit results packed under the 4-bit header
`define ADC_SLOTS_PER_WORD 5

// channels walked when vmm_id selects all
`define ADC_NUM_CHANNELS 8

`endif

/* verilog.f */
+incdir+include
verilog/adc_types_pkg.sv
verilog/frame_pkg.sv
verilog/adc_links.sv
verilog/adc_run_config.sv
verilog/sample_sequencer.sv
verilog/word_packer.sv
verilog/frame_writer.sv
verilog/xadc_frame_top.sv
bench/clock_gen.sv
bench/tb_xadc_frame.sv

/* verilog/adc_links.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////
// sequencer to packer
////////////////////////////////////////

interface sample_if;
    import adc_types_pkg::*;

    logic     sample_valid;    // one-cycle strobe per result
    sample_t  sample_result;
    channel_t sample_channel;
    logic     sample_last;     // final sample of the channel
    logic     channel_done;    // word with the last sample has left

    modport source
    (
        output sample_valid, sample_result, sample_channel, sample_last,
        input  channel_done
    );

    modport sink
    (
        input  sample_valid, sample_result, sample_channel, sample_last,
        output channel_done
    );
endinterface

////////////////////////////////////////
// packer to writer
////////////////////////////////////////

interface word_if;
    import frame_pkg::*;

    logic  word_valid;     // one-cycle strobe per word
    word_t word_data;
    logic  word_last;      // closes the channel
    logic  word_written;   // pulse after a last word hits the FIFO

    modport source (output word_valid, word_data, word_last, input word_written);

    modport sink (input word_valid, word_data, word_last, output word_written);
endinterface

`default_nettype wire

/* verilog/adc_run_config.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_frame_params.svh"

module adc_run_config
(
    input  logic                         clk125,
    input  logic                         rst,
    input  logic                         load,
    input  logic                         next_channel,
    input  adc_types_pkg::vmm_id_t       vmm_id,
    input  adc_types_pkg::sample_count_t sample_size,
    input  adc_types_pkg::delay_t        delay_in,
    output adc_types_pkg::channel_t      channel,
    output logic                         last_channel,
    output adc_types_pkg::sample_count_t run_samples,
    output adc_types_pkg::delay_t        run_delay
);
    import adc_types_pkg::*;

    localparam channel_t last_ch = channel_t'(`ADC_NUM_CHANNELS - 1);

    logic all_channels;  // walking 0..7 instead of one channel

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            all_channels <= 1'b0;
            channel      <= '0;
        end
        else if (load)
        begin
            all_channels <= (vmm_id[3:0] > 4'd7);
            channel      <= (vmm_id[3:0] > 4'd7) ? '0 : vmm_id[2:0];
        end
        else if (next_channel && !last_channel)
            channel <= channel + 3'd1;
    end

    // settings only sampled at run start
    always_ff @(posedge clk125)
    begin
        if (load)
        begin
            run_samples <= sample_size;
            run_delay   <= delay_in;
        end
    end

    assign last_channel = !all_channels || (channel == last_ch);

endmodule

`default_nettype wire

/* verilog/adc_types_pkg.sv */
`default_nettype none

package adc_types_pkg;

    ////////////////////////////////////////
    // converter side
    ////////////////////////////////////////

    // one conversion result
    typedef logic [11:0] sample_t;

    // front-end channel number, 0 to 7
    typedef logic [2:0] channel_t;

    ////////////////////////////////////////
    // run settings
    ////////////////////////////////////////

    typedef logic [10:0] sample_count_t;  // conversions per channel

    typedef logic [17:0] delay_t;         // idle cycles between conversions, minus one

    // low nibble above 7 means read every channel
    typedef logic [15:0] vmm_id_t;

endpackage

`default_nettype wire

/* verilog/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    ////////////////////////////////////////
    // FIFO side
    ////////////////////////////////////////

    // header nibble plus five results
    typedef logic [63:0] word_t;

    typedef logic [2:0] slot_t;  // result position inside a word

    // words in the current frame, this one included
    typedef logic [11:0] frame_len_t;

endpackage

`default_nettype wire

/* verilog/frame_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_frame_params.svh"

module frame_writer
(
    input  logic                    clk125,
    input  logic                    rst,
    word_if.sink                    wrd,
    output frame_pkg::word_t        fifo_bus,
    output logic                    data_fifo_enable,
    output frame_pkg::frame_len_t   packet_len,
    output logic                    end_of_data
);
    import frame_pkg::*;

    frame_len_t word_cnt;    // words already in this frame
    frame_len_t next_len;
    logic       frame_end;
    logic       last_q;      // word on the bus closes a channel

    assign next_len  = word_cnt + 12'd1;
    assign frame_end = wrd.word_last || (next_len == frame_len_t'(`ADC_MAX_FRAME_WORDS));

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            word_cnt         <= '0;
            last_q           <= 1'b0;
            data_fifo_enable <= 1'b0;
            end_of_data      <= 1'b0;
            wrd.word_written <= 1'b0;
        end
        else
        begin
            data_fifo_enable <= wrd.word_valid;
            end_of_data      <= wrd.word_valid && frame_end;
            wrd.word_written <= data_fifo_enable && last_q;  // cycle after the strobe
            if (wrd.word_valid)
            begin
                word_cnt <= frame_end ? '0 : next_len;
                last_q   <= wrd.word_last;
            end
        end
    end

    // bus and length change only with a strobe
    always_ff @(posedge clk125)
    begin
        if (wrd.word_valid)
        begin
            fifo_bus   <= wrd.word_data;
            packet_len <= next_len;
        end
    end

endmodule

`default_nettype wire

/* verilog/sample_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_sequencer
(
    input  logic                         clk125,
    input  logic                         rst,
    input  logic                         data_in_rdy,
    input  logic                         udp_done,
    input  logic                         conv_done,
    input  adc_types_pkg::sample_t       conv_result,
    output logic                         conv_start,
    output adc_types_pkg::channel_t      conv_channel,
    output logic                         busy,
    output logic                         load,
    output logic                         next_channel,
    input  adc_types_pkg::channel_t      channel,
    input  logic                         last_channel,
    input  adc_types_pkg::sample_count_t run_samples,
    input  adc_types_pkg::delay_t        run_delay,
    sample_if.source                     smp
);
    import adc_types_pkg::*;

    typedef enum logic [2:0]
    {
        st_idle,
        st_convert,
        st_wait_conv,
        st_space,
        st_wait_channel,
        st_wait_release
    } state_t;

    state_t        state;
    sample_count_t smp_cnt;   // results taken on this channel
    delay_t        dly_cnt;
    logic          last_smp;

    assign last_smp = (smp_cnt + 11'd1) >= run_samples;

    assign load         = (state == st_idle) && data_in_rdy;
    assign next_channel = (state == st_wait_channel) && smp.channel_done && !last_channel;
    assign conv_start   = (state == st_convert);  // one cycle per visit
    assign conv_channel = channel;                // only moves between channels
    assign busy         = (state != st_idle);

    ////////////////////////////////////////
    // run FSM
    ////////////////////////////////////////

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            state            <= st_idle;
            smp_cnt          <= '0;
            dly_cnt          <= '0;
            smp.sample_valid <= 1'b0;
        end
        else
        begin
            smp.sample_valid <= 1'b0;
            case (state)
                st_idle:
                    if (data_in_rdy)
                    begin
                        smp_cnt <= '0;
                        state   <= st_convert;
                    end
                st_convert:
                    state <= st_wait_conv;
                st_wait_conv:
                    if (conv_done)
                    begin
                        smp.sample_valid <= 1'b1;
                        smp_cnt          <= smp_cnt + 11'd1;
                        dly_cnt          <= '0;
                        state            <= last_smp ? st_wait_channel : st_space;
                    end
                st_space:
                    if (dly_cnt == run_delay)
                        state <= st_convert;
                    else
                        dly_cnt <= dly_cnt + 18'd1;
                st_wait_channel:   // hold until the closing word is in the FIFO
                    if (smp.channel_done)
                    begin
                        if (last_channel)
                            state <= st_wait_release;
                        else
                        begin
                            smp_cnt <= '0;
                            state   <= st_convert;
                        end
                    end
                st_wait_release:
                    if (!data_in_rdy && udp_done)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // result and tags ride with sample_valid
    always_ff @(posedge clk125)
    begin
        if ((state == st_wait_conv) && conv_done)
        begin
            smp.sample_result  <= conv_result;
            smp.sample_channel <= channel;
            smp.sample_last    <= last_smp;
        end
    end

endmodule

`default_nettype wire

/* verilog/word_packer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "adc_frame_params.svh"

module word_packer
(
    input  logic     clk125,
    input  logic     rst,
    sample_if.sink   smp,
    word_if.source   wrd
);
    import frame_pkg::*;

    localparam slot_t top_slot = slot_t'(`ADC_SLOTS_PER_WORD - 1);

    slot_t slot_cnt;    // next free slot
    word_t acc;         // word being filled
    word_t next_word;
    logic  emit;

    ////////////////////////////////////////
    // slot insert
    ////////////////////////////////////////

    always_comb
    begin
        next_word        = acc;
        next_word[63:60] = {1'b0, smp.sample_channel};  // header nibble
        for (int k = 0; k < `ADC_SLOTS_PER_WORD; k++)
        begin
            if (slot_cnt == slot_t'(k))
                next_word[12*k +: 12] = smp.sample_result;
        end
    end

    // full word or end of channel
    assign emit = smp.sample_valid && (smp.sample_last || (slot_cnt == top_slot));

    always_ff @(posedge clk125)
    begin
        if (rst)
        begin
            slot_cnt       <= '0;
            acc            <= '0;
            wrd.word_valid <= 1'b0;
        end
        else
        begin
            wrd.word_valid <= emit;
            if (smp.sample_valid)
            begin
                if (emit)
                begin
                    acc      <= '0;  // unused slots stay zero
                    slot_cnt <= '0;
                end
                else
                begin
                    acc      <= next_word;
                    slot_cnt <= slot_cnt + 3'd1;
                end
            end
        end
    end

    always_ff @(posedge clk125)
    begin
        if (emit)
        begin
            wrd.word_data <= next_word;
            wrd.word_last <= smp.sample_last;
        end
    end

    assign smp.channel_done = wrd.word_written;

endmodule

`default_nettype wire

/* verilog/xadc_frame_top.sv */
`timescale 1ns/1ps
`default_nettype none

module xadc_frame_top
(
    input  logic                         clk125,
    input  logic                         rst,
    input  logic                         data_in_rdy,
    input  adc_types_pkg::vmm_id_t       vmm_id,
    input  adc_types_pkg::sample_count_t sample_size,
    input  adc_types_pkg::delay_t        delay_in,
    input  logic                         udp_done,
    input  logic                         conv_done,
    input  adc_types_pkg::sample_t       conv_result,
    output logic                         conv_start,
    output adc_types_pkg::channel_t      conv_channel,
    output logic                         busy,
    output frame_pkg::word_t             fifo_bus,
    output logic                         data_fifo_enable,
    output frame_pkg::frame_len_t        packet_len,
    output logic                         end_of_data
);
    import adc_types_pkg::*;

    logic          load;
    logic          next_channel;
    channel_t      channel;
    logic          last_channel;
    sample_count_t run_samples;
    delay_t        run_delay;

    sample_if smp_link ();
    word_if   wrd_link ();

    ////////////////////////////////////////
    // run control
    ////////////////////////////////////////

    adc_run_config cfg0
    (
        .clk125       (clk125),
        .rst          (rst),
        .load         (load),
        .next_channel (next_channel),
        .vmm_id       (vmm_id),
        .sample_size  (sample_size),
        .delay_in     (delay_in),
        .channel      (channel),
        .last_channel (last_channel),
        .run_samples  (run_samples),
        .run_delay    (run_delay)
    );

    sample_sequencer seq0
    (
        .clk125       (clk125),
        .rst          (rst),
        .data_in_rdy  (data_in_rdy),
        .udp_done     (udp_done),
        .conv_done    (conv_done),
        .conv_result  (conv_result),
        .conv_start   (conv_start),
        .conv_channel (conv_channel),
        .busy         (busy),
        .load         (load),
        .next_channel (next_channel),
        .channel      (channel),
        .last_channel (last_channel),
        .run_samples  (run_samples),
        .run_delay    (run_delay),
        .smp          (smp_link.source)
    );

    ////////////////////////////////////////
    // data path to the FIFO
    ////////////////////////////////////////

    word_packer pack0
    (
        .clk125 (clk125),
        .rst    (rst),
        .smp    (smp_link.sink),
        .wrd    (wrd_link.source)
    );

    frame_writer wr0
    (
        .clk125           (clk125),
        .rst              (rst),
        .wrd              (wrd_link.sink),
        .fifo_bus         (fifo_bus),
        .data_fifo_enable (data_fifo_enable),
        .packet_len       (packet_len),
        .end_of_data      (end_of_data)
    );

endmodule

`default_nettype wire
